/* Makefile */
VERILATOR  ?= verilator
TOP        := crc_link_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+rtl
rtl/crc_link_pkg.sv
rtl/crc5_byte_gen.sv
rtl/byte_fifo.sv
rtl/frame_tx.sv
rtl/frame_rx.sv
rtl/crc_link_top.sv
verification/clk_gen.sv
verification/crc_link_checker.sv
verification/crc_link_tb.sv

/* rtl/byte_fifo.sv */
`include "crc_link_defines.svh"

`default_nettype none

module byte_fifo #(
	parameter int DEPTH = `CRC_LINK_DEPTH
) (
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire crc_link_pkg::byte_t push_data,
	input wire push_last,
	input wire push_err,
	input wire pop,
	output logic empty,
	output crc_link_pkg::byte_t head_data,
	output logic head_last,
	output logic head_err
);
	import crc_link_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	byte_t data_mem [DEPTH];
	logic last_mem [DEPTH];
	logic err_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_pop;

	assign do_pop = pop && !empty;
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (push) begin
			data_mem[wr_ptr] <= push_data;
			last_mem[wr_ptr] <= push_last;
			err_mem[wr_ptr] <= push_err;
		end
	end

	// pointers wrap on their own for power-of-two depths
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_data = data_mem[rd_ptr];
	assign head_last = last_mem[rd_ptr];
	assign head_err = err_mem[rd_ptr];

endmodule

`default_nettype wire

/* rtl/crc5_byte_gen.sv */
`include "crc_link_defines.svh"

`default_nettype none

module crc5_byte_gen (
	input wire clk,
	input wire rst_n,
	input wire init,
	input wire en,
	input wire crc_link_pkg::byte_t data,
	output crc_link_pkg::crc5_t crc
);
	import crc_link_pkg::*;

	crc5_t crc_next;

	// eight serial steps, msb first
	always_comb begin : unroll
		crc5_t c;
		logic fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = c[4] ^ data[i];
			c = {c[3], c[2] ^ fb, c[1], c[0], fb};
		end
		crc_next = c;
	end

	// init has priority over en
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crc <= `CRC_LINK_SEED;
		end else if (init) begin
			crc <= `CRC_LINK_SEED;
		end else if (en) begin
			crc <= crc_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/crc_link_defines.svh */
`default_nettype none

`ifndef CRC_LINK_DEFINES_SVH
`define CRC_LINK_DEFINES_SVH

// entries per byte FIFO, also the starting credit on both sides
`define CRC_LINK_DEPTH 8

// must hold the value CRC_LINK_DEPTH
`define CRC_LINK_CREDIT_W 4

// longest payload in bytes
`define CRC_LINK_MAX_LEN 16

// x^5 + x^3 + 1 start value
`define CRC_LINK_SEED 5'h09

`endif

`default_nettype wire

/* rtl/crc_link_pkg.sv */
`default_nettype none

package crc_link_pkg;

	// payload or link byte
	typedef logic [7:0] byte_t;

	typedef logic [4:0] crc5_t;

	typedef enum logic {
		TX_DATA,
		TX_CRC
	} tx_state_t;

	// RX_HOLD means one payload byte waits in the hold register
	typedef enum logic {
		RX_EMPTY,
		RX_HOLD
	} rx_state_t;

endpackage

`default_nettype wire

/* rtl/crc_link_top.sv */
`default_nettype none

module crc_link_top (
	input wire clk,
	input wire rst_n,
	// source side
	input wire in_valid,
	input wire crc_link_pkg::byte_t in_data,
	input wire in_last,
	output wire in_credit,
	// link out of the transmitter
	output wire link_valid,
	output wire crc_link_pkg::byte_t link_data,
	output wire link_last,
	input wire [1:0] tx_link_credit,
	// link into the receiver
	input wire rx_link_valid,
	input wire crc_link_pkg::byte_t rx_link_data,
	input wire rx_link_last,
	output wire [1:0] rx_link_credit,
	// consumer side
	input wire out_pop,
	output wire out_valid,
	output wire crc_link_pkg::byte_t out_data,
	output wire out_last,
	output wire out_err
);

	frame_tx u_tx (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_last(in_last),
		.in_credit(in_credit),
		.link_valid(link_valid),
		.link_data(link_data),
		.link_last(link_last),
		.link_credit(tx_link_credit)
	);

	frame_rx u_rx (
		.clk(clk),
		.rst_n(rst_n),
		.link_valid(rx_link_valid),
		.link_data(rx_link_data),
		.link_last(rx_link_last),
		.link_credit(rx_link_credit),
		.out_pop(out_pop),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_last(out_last),
		.out_err(out_err)
	);

endmodule

`default_nettype wire

/* rtl/frame_rx.sv */
`include "crc_link_defines.svh"

`default_nettype none

module frame_rx (
	input wire clk,
	input wire rst_n,
	input wire link_valid,
	input wire crc_link_pkg::byte_t link_data,
	input wire link_last,
	output logic [1:0] link_credit,
	input wire out_pop,
	output logic out_valid,
	output crc_link_pkg::byte_t out_data,
	output logic out_last,
	output logic out_err
);
	import crc_link_pkg::*;

	rx_state_t state;
	byte_t hold_data;
	crc5_t crc;
	logic payload_byte;
	logic crc_byte;
	logic crc_bad;
	logic fifo_push;
	logic fifo_empty;
	logic pop_ok;

	assign payload_byte = link_valid && !link_last;
	assign crc_byte = link_valid && link_last;

	// pad bits must be zero as well
	assign crc_bad = (link_data[4:0] != crc) || (link_data[7:5] != 3'b000);

	// held byte moves out when anything new arrives
	assign fifo_push = link_valid && (state == RX_HOLD);
	assign pop_ok = out_pop && !fifo_empty;
	assign out_valid = !fifo_empty;

	byte_fifo #(
		.DEPTH(`CRC_LINK_DEPTH)
	) u_out_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(fifo_push),
		.push_data(hold_data),
		.push_last(link_last),
		.push_err(crc_byte && crc_bad),
		.pop(pop_ok),
		.empty(fifo_empty),
		.head_data(out_data),
		.head_last(out_last),
		.head_err(out_err)
	);

	crc5_byte_gen u_crc (
		.clk(clk),
		.rst_n(rst_n),
		.init(crc_byte),
		.en(payload_byte),
		.data(link_data),
		.crc(crc)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_EMPTY;
		end else if (payload_byte) begin
			state <= RX_HOLD;
		end else if (crc_byte) begin
			state <= RX_EMPTY;
		end
	end

	always_ff @(posedge clk) begin
		if (payload_byte)
			hold_data <= link_data;
	end

	// crc byte is dropped here, so its credit goes straight back
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			link_credit <= 2'd0;
		else
			link_credit <= {1'b0, pop_ok} + {1'b0, crc_byte};
	end

endmodule

`default_nettype wire

/* rtl/frame_tx.sv */
`include "crc_link_defines.svh"

`default_nettype none

module frame_tx (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	input wire crc_link_pkg::byte_t in_data,
	input wire in_last,
	output logic in_credit,
	output logic link_valid,
	output crc_link_pkg::byte_t link_data,
	output logic link_last,
	input wire [1:0] link_credit
);
	import crc_link_pkg::*;

	localparam int CW = `CRC_LINK_CREDIT_W;

	tx_state_t state;
	logic [CW-1:0] link_credits;
	logic fifo_empty;
	byte_t head_data;
	logic head_last;
	logic pop;
	logic send_crc;
	logic spend;
	crc5_t crc;

	byte_fifo #(
		.DEPTH(`CRC_LINK_DEPTH)
	) u_in_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(in_valid),
		.push_data(in_data),
		.push_last(in_last),
		.push_err(1'b0),
		.pop(pop),
		.empty(fifo_empty),
		.head_data(head_data),
		.head_last(head_last),
		.head_err()
	);

	assign pop = (state == TX_DATA) && !fifo_empty && (link_credits != '0);
	assign send_crc = (state == TX_CRC) && (link_credits != '0);
	assign spend = pop || send_crc;

	// reseeded as the crc byte leaves
	crc5_byte_gen u_crc (
		.clk(clk),
		.rst_n(rst_n),
		.init(send_crc),
		.en(pop),
		.data(head_data),
		.crc(crc)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_DATA;
		end else begin
			case (state)
				TX_DATA: if (pop && head_last) state <= TX_CRC;
				TX_CRC: if (send_crc) state <= TX_DATA;
				default: state <= TX_DATA;
			endcase
		end
	end

	// one credit per link byte, up to two back per cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			link_credits <= CW'(`CRC_LINK_DEPTH);
		else
			link_credits <= link_credits + CW'(link_credit) - CW'(spend);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_credit <= 1'b0;
			link_valid <= 1'b0;
			link_last <= 1'b0;
		end else begin
			in_credit <= pop;
			link_valid <= spend;
			link_last <= send_crc;
		end
	end

	// crc byte is zero padded above the five crc bits
	always_ff @(posedge clk) begin
		if (pop)
			link_data <= head_data;
		else if (send_crc)
			link_data <= {3'b000, crc};
	end

endmodule

`default_nettype wire

/* verification/clk_gen.sv */
`default_nettype none

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// held low for five rising edges
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* verification/crc_link_checker.sv */
`include "crc_link_defines.svh"

`default_nettype none

module crc_link_checker (
	input wire clk,
	input wire rst_n,
	input wire in_credit,
	input wire link_valid,
	input wire link_last,
	input wire [1:0] rx_link_credit,
	input wire out_valid,
	input wire out_last,
	input wire out_err,
	input wire [`CRC_LINK_CREDIT_W-1:0] tx_credits
);

	localparam int CW = `CRC_LINK_CREDIT_W;
	localparam logic [CW-1:0] MAX_CREDITS = CW'(`CRC_LINK_DEPTH);

	// a link byte follows a cycle with a nonzero counter
	assert property (@(posedge clk) disable iff (!rst_n)
		tx_credits == '0 |=> !link_valid)
	else $error("link byte sent with no link credit");

	assert property (@(posedge clk) disable iff (!rst_n)
		tx_credits <= MAX_CREDITS)
	else $error("link credit counter above the receive buffer depth");

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && out_err |-> out_last)
	else $error("out_err raised on a byte that is not the last of its frame");

	assert property (@(posedge clk)
		!rst_n |-> !in_credit && !link_valid && !link_last && rx_link_credit == 2'd0 && !out_valid)
	else $error("control output high during reset");

endmodule

`default_nettype wire

/* verification/crc_link_tb.sv */
`include "crc_link_defines.svh"

`default_nettype none

module crc_link_tb;
	import crc_link_pkg::*;

	localparam int NUM_FRAMES = 12;
	localparam int NONE = -1;

	// length, corrupted link byte (length means the crc byte), xor mask, idle cycles before
	int frame_tab [NUM_FRAMES][4] = '{
		'{4, NONE, 0, 0}, '{1, NONE, 0, 0}, '{`CRC_LINK_MAX_LEN, NONE, 0, 0},
		'{1, NONE, 0, 0}, '{`CRC_LINK_MAX_LEN, NONE, 0, 0}, '{5, 2, 8'h10, 3},
		'{5, 5, 8'h01, 0}, '{3, 3, 8'h80, 0}, '{7, 0, 8'h01, 2},
		'{`CRC_LINK_MAX_LEN, `CRC_LINK_MAX_LEN - 1, 8'h40, 0}, '{2, NONE, 0, 5},
		'{9, NONE, 0, 0}
	};

	logic clk;
	logic rst_n;
	logic in_valid;
	byte_t in_data;
	logic in_last;
	logic in_credit;
	logic link_valid;
	byte_t link_data;
	logic link_last;
	logic [1:0] rx_link_credit;
	logic out_pop = 1'b0;
	logic out_valid;
	byte_t out_data;
	logic out_last;
	logic out_err;
	byte_t link_mask;

	integer seed = 32'h53a0c3d1;
	byte_t payload [$];
	byte_t exp_data [$];
	logic exp_last [$];
	logic exp_err [$];
	int total_bytes = 0;
	int bytes_sent = 0;
	int checked = 0;
	int credits_back;
	int cycle_cnt;
	int link_frame;
	int link_idx;

	clk_gen u_clk (
		.clk(clk),
		.rst_n(rst_n)
	);

	// link looped back, with an optional bit flip on the way
	crc_link_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_last(in_last),
		.in_credit(in_credit),
		.link_valid(link_valid),
		.link_data(link_data),
		.link_last(link_last),
		.tx_link_credit(rx_link_credit),
		.rx_link_valid(link_valid),
		.rx_link_data(link_data ^ link_mask),
		.rx_link_last(link_last),
		.rx_link_credit(rx_link_credit),
		.out_pop(out_pop),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_last(out_last),
		.out_err(out_err)
	);

	bind crc_link_top crc_link_checker u_checker (
		.clk(clk),
		.rst_n(rst_n),
		.in_credit(in_credit),
		.link_valid(link_valid),
		.link_last(link_last),
		.rx_link_credit(rx_link_credit),
		.out_valid(out_valid),
		.out_last(out_last),
		.out_err(out_err),
		.tx_credits(u_tx.link_credits)
	);

	// shift left, xor in x^3 + 1 when the outgoing bit differs from the data bit
	function automatic crc5_t crc5_step(crc5_t c, byte_t b);
		crc5_t r;
		r = c;
		for (int k = 7; k >= 0; k--) begin
			if (r[4] ^ b[k])
				r = {r[3:0], 1'b0} ^ 5'b01001;
			else
				r = {r[3:0], 1'b0};
		end
		return r;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		if (got !== exp)
			stop_run($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_head();
		logic last_e;
		logic err_e;
		if (exp_data.size() == 0) begin
			stop_run("output byte popped with nothing left in the expected queue");
		end else begin
			last_e = exp_last.pop_front();
			err_e = exp_err.pop_front();
			check_byte("out_data", out_data, exp_data.pop_front());
			check_flag("out_last", out_last, last_e);
			if (last_e)
				check_flag("out_err", out_err, err_e);
			checked++;
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			link_frame <= 0;
			link_idx <= 0;
		end else if (link_valid) begin
			if (link_last) begin
				link_frame <= link_frame + 1;
				link_idx <= 0;
			end else begin
				link_idx <= link_idx + 1;
			end
		end
	end

	always_comb begin
		link_mask = 8'h00;
		if (link_valid && link_frame < NUM_FRAMES && frame_tab[link_frame][1] == link_idx)
			link_mask = byte_t'(frame_tab[link_frame][2]);
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			credits_back <= 0;
		else if (in_credit)
			credits_back <= credits_back + 1;
	end

	// pop window closed for long stretches so the link backs up
	always @(posedge clk) begin
		if (!rst_n) begin
			out_pop <= 1'b0;
			cycle_cnt <= 0;
		end else begin
			if (out_valid && out_pop)
				check_head();
			cycle_cnt <= cycle_cnt + 1;
			out_pop <= (cycle_cnt % 256 >= 96) && (($random(seed) & 3) != 0);
		end
	end

	initial begin
		wait (rst_n === 1'b1);
		repeat (total_bytes * 50 + 1000) @(posedge clk);
		stop_run("timeout: the frames did not drain before the watchdog limit");
	end

	initial begin : main
		crc5_t tx_crc;
		crc5_t rx_crc;
		byte_t b;
		byte_t crc_byte;
		int len;
		in_valid = 1'b0;
		in_data = 8'h00;
		in_last = 1'b0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			len = frame_tab[f][0];
			tx_crc = `CRC_LINK_SEED;
			rx_crc = `CRC_LINK_SEED;
			for (int i = 0; i < len; i++) begin
				b = byte_t'($random(seed));
				payload.push_back(b);
				tx_crc = crc5_step(tx_crc, b);
				if (frame_tab[f][1] == i)
					b = b ^ byte_t'(frame_tab[f][2]);
				rx_crc = crc5_step(rx_crc, b);
				exp_data.push_back(b);
				exp_last.push_back(i == len - 1);
				exp_err.push_back(1'b0);
			end
			crc_byte = {3'b000, tx_crc};
			if (frame_tab[f][1] == len)
				crc_byte = crc_byte ^ byte_t'(frame_tab[f][2]);
			exp_err[exp_err.size() - 1] = (crc_byte != {3'b000, rx_crc});
			total_bytes += len;
		end
		wait (rst_n === 1'b1);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			repeat (frame_tab[f][3]) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
			for (int i = 0; i < frame_tab[f][0]; i++) begin
				@(posedge clk);
				// no write until a credit is back
				while (`CRC_LINK_DEPTH + credits_back - bytes_sent == 0) begin
					in_valid <= 1'b0;
					@(posedge clk);
				end
				in_valid <= 1'b1;
				in_data <= payload[bytes_sent];
				in_last <= (i == frame_tab[f][0] - 1);
				bytes_sent++;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		wait (checked == total_bytes);
		repeat (4) @(posedge clk);
		if (out_valid) begin
			stop_run("output queue still holds data after the last expected byte");
		end else if (credits_back != bytes_sent) begin
			stop_run($sformatf("FAILED at time %0t: %0d input credits returned for %0d bytes",
				$time, credits_back, bytes_sent));
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
